/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - source/fetch_pkg.sv
  - source/fetch_stage.sv
  - source/ibus_wb_master.sv
  - source/fetch_queue.sv
  - source/fetch_top.sv
  - target: test
    files:
      - testbench/wb_imem_model.sv
      - testbench/tb_fetch_top.sv

/* source/fetch_pkg.sv */
package fetch_pkg;

    // pc and bus address
    typedef logic [31:0] addr_t;

    // instruction word, also the bus read data
    typedef logic [31:0] inst_t;

    // exception cause code as seen by decode
    typedef logic [3:0] exc_cause_t;

    // fetch exception causes, riscv numbering
    localparam exc_cause_t EXC_INSTR_MISALIGNED   = 4'd0;
    localparam exc_cause_t EXC_INSTR_ACCESS_FAULT = 4'd1;
    localparam exc_cause_t EXC_INSTR_PAGE_FAULT   = 4'd12;

    // first pc after reset
    localparam addr_t RESET_PC = 32'h0000_024C;

    // everything at or above this is unmapped
    localparam addr_t MAPPED_LIMIT = 32'h8000_0000;

    // step between two sequential fetches
    localparam addr_t INST_BYTES = 32'h0000_0004;

    // instruction queue towards decode
    localparam int FETCH_QUEUE_DEPTH = 2;

    // byte lanes on a full word read
    localparam logic [3:0] WB_SEL_ALL = 4'b1111;

    // next pc source
    typedef enum logic [1:0] {
        NEXT_PC_SEL_PC,
        NEXT_PC_SEL_PC_4,
        NEXT_PC_SEL_JUMP
    } next_pc_sel_t;

    // instruction bus master states
    typedef enum logic [1:0] {
        IBUS_IDLE,
        IBUS_BUS,
        IBUS_RESPOND
    } ibus_state_t;

endpackage

/* source/fetch_queue.sv */
`timescale 1ns/1ns

module fetch_queue (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    input  logic                   push_i,
    input  fetch_pkg::addr_t       push_pc_i,
    input  fetch_pkg::inst_t       push_inst_i,
    input  logic                   push_ex_valid_i,
    input  fetch_pkg::exc_cause_t  push_ex_cause_i,
    input  logic                   out_ready_i,
    output logic                   full_o,
    output logic                   out_valid_o,
    output fetch_pkg::addr_t       out_pc_o,
    output fetch_pkg::inst_t       out_inst_o,
    output logic                   out_ex_valid_o,
    output fetch_pkg::exc_cause_t  out_ex_cause_o
);
    // entry storage
    fetch_pkg::addr_t      pc_mem    [fetch_pkg::FETCH_QUEUE_DEPTH];
    fetch_pkg::inst_t      inst_mem  [fetch_pkg::FETCH_QUEUE_DEPTH];
    logic                  exv_mem   [fetch_pkg::FETCH_QUEUE_DEPTH];
    fetch_pkg::exc_cause_t cause_mem [fetch_pkg::FETCH_QUEUE_DEPTH];

    // one bit pointers wrap by themselves at depth two
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       do_push;
    logic       do_pop;

    assign full_o      = count_q == 2'(fetch_pkg::FETCH_QUEUE_DEPTH);
    assign out_valid_o = count_q != 2'd0;

    assign do_push = push_i && !full_o;
    assign do_pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else if (flush_i) begin
            // drop everything fetched on the old path
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (do_pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            // push and pop together keep the count
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    // write port
    always_ff @(posedge clk_i) begin
        if (do_push && !flush_i) begin
            pc_mem[wr_ptr_q]    <= push_pc_i;
            inst_mem[wr_ptr_q]  <= push_inst_i;
            exv_mem[wr_ptr_q]   <= push_ex_valid_i;
            cause_mem[wr_ptr_q] <= push_ex_cause_i;
        end
    end

    // head entry straight to decode
    assign out_pc_o       = pc_mem[rd_ptr_q];
    assign out_inst_o     = inst_mem[rd_ptr_q];
    assign out_ex_valid_o = exv_mem[rd_ptr_q];
    assign out_ex_cause_o = cause_mem[rd_ptr_q];

    // the stage must respect full, an ignored push loses an entry
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        push_i |-> !full_o);

endmodule

/* source/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   redirect_valid_i,
    input  fetch_pkg::addr_t       redirect_pc_i,
    input  logic                   busy_i,
    input  logic                   resp_valid_i,
    input  fetch_pkg::inst_t       resp_data_i,
    input  logic                   resp_access_fault_i,
    input  logic                   resp_page_fault_i,
    input  logic                   queue_full_i,
    output logic                   req_valid_o,
    output fetch_pkg::addr_t       req_addr_o,
    output logic                   push_o,
    output fetch_pkg::addr_t       push_pc_o,
    output fetch_pkg::inst_t       push_inst_o,
    output logic                   push_ex_valid_o,
    output fetch_pkg::exc_cause_t  push_ex_cause_o
);
    fetch_pkg::addr_t        pc_q;
    fetch_pkg::addr_t        next_pc;
    fetch_pkg::next_pc_sel_t next_pc_sel;

    // one request in flight at most
    logic outstanding_q;
    // in flight request predates a redirect
    logic stale_q;
    // misaligned entry already handed to the queue
    logic ex_sent_q;

    logic pc_misaligned;
    logic ex_access_fault;
    logic ex_page_fault;
    logic resp_live;
    logic push_resp;
    logic push_misaligned;

    // only word aligned fetches, no compressed support
    assign pc_misaligned = |pc_q[1:0];

    // response that still belongs to the current pc
    assign resp_live = resp_valid_i && !stale_q;
    // redirect throws away whatever arrives this cycle
    assign push_resp = resp_live && !redirect_valid_i;
    // one exception entry, no bus cycle
    assign push_misaligned = pc_misaligned && !ex_sent_q && !queue_full_i && !redirect_valid_i;

    // redirect first, then advance on a response
    always_comb begin
        if (redirect_valid_i) begin
            next_pc_sel = fetch_pkg::NEXT_PC_SEL_JUMP;
        end else if (resp_live) begin
            next_pc_sel = fetch_pkg::NEXT_PC_SEL_PC_4;
        end else begin
            next_pc_sel = fetch_pkg::NEXT_PC_SEL_PC;
        end
    end

    always_comb begin
        case (next_pc_sel)
            fetch_pkg::NEXT_PC_SEL_PC_4: next_pc = pc_q + fetch_pkg::INST_BYTES;
            fetch_pkg::NEXT_PC_SEL_JUMP: next_pc = redirect_pc_i;
            default:                     next_pc = pc_q;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q          <= fetch_pkg::RESET_PC;
            outstanding_q <= 1'b0;
            stale_q       <= 1'b0;
            ex_sent_q     <= 1'b0;
        end else begin
            pc_q <= next_pc;
            // req and resp never overlap, resp needs outstanding set
            if (req_valid_o) begin
                outstanding_q <= 1'b1;
            end else if (resp_valid_i) begin
                outstanding_q <= 1'b0;
            end
            // resp in the redirect cycle is dropped directly
            if (resp_valid_i) begin
                stale_q <= 1'b0;
            end else if (redirect_valid_i && outstanding_q) begin
                stale_q <= 1'b1;
            end
            // held pc stays quiet until the next redirect
            if (redirect_valid_i) begin
                ex_sent_q <= 1'b0;
            end else if (push_misaligned) begin
                ex_sent_q <= 1'b1;
            end
        end
    end

    // issue only with room in the queue for the answer
    assign req_valid_o = !pc_misaligned && !busy_i && !queue_full_i && !outstanding_q
                         && !redirect_valid_i;
    assign req_addr_o  = pc_q;

    // faults reported by the bus master
    assign ex_access_fault = resp_live && resp_access_fault_i;
    assign ex_page_fault   = resp_live && resp_page_fault_i;

    // exception ordering
    always_comb begin
        if (pc_misaligned) begin
            push_ex_valid_o = 1'b1;
            push_ex_cause_o = fetch_pkg::EXC_INSTR_MISALIGNED;
        end else if (ex_access_fault) begin
            push_ex_valid_o = 1'b1;
            push_ex_cause_o = fetch_pkg::EXC_INSTR_ACCESS_FAULT;
        end else if (ex_page_fault) begin
            push_ex_valid_o = 1'b1;
            push_ex_cause_o = fetch_pkg::EXC_INSTR_PAGE_FAULT;
        end else begin
            push_ex_valid_o = 1'b0;
            push_ex_cause_o = fetch_pkg::EXC_INSTR_MISALIGNED;
        end
    end

    // pc only moves after the push, so it still names the entry
    assign push_o      = push_resp || push_misaligned;
    assign push_pc_o   = pc_q;
    assign push_inst_o = push_resp ? resp_data_i : '0;

    // a misaligned pc never has a live request, a new one or one in flight
    a_req_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (req_valid_o || (outstanding_q && !stale_q)) |-> !pc_misaligned);

    // the slot was reserved when the request left
    a_push_room: assert property (@(posedge clk_i) disable iff (!rstn_i)
        push_o |-> !queue_full_i);

    // master only answers what was asked
    a_resp_expected: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_i |-> outstanding_q);

endmodule

/* source/fetch_top.sv */
`timescale 1ns/1ns

module fetch_top (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   redirect_valid_i,
    input  fetch_pkg::addr_t       redirect_pc_i,
    output logic                   cyc_o,
    output logic                   stb_o,
    output logic                   we_o,
    output logic [3:0]             sel_o,
    output fetch_pkg::addr_t       adr_o,
    input  fetch_pkg::inst_t       dat_i,
    input  logic                   ack_i,
    input  logic                   err_i,
    input  logic                   out_ready_i,
    output logic                   out_valid_o,
    output fetch_pkg::addr_t       out_pc_o,
    output fetch_pkg::inst_t       out_inst_o,
    output logic                   out_ex_valid_o,
    output fetch_pkg::exc_cause_t  out_ex_cause_o
);
    // stage to bus master
    logic                  req_valid;
    fetch_pkg::addr_t      req_addr;
    logic                  busy;
    logic                  resp_valid;
    fetch_pkg::inst_t      resp_data;
    logic                  resp_access_fault;
    logic                  resp_page_fault;

    // stage to queue
    logic                  push;
    fetch_pkg::addr_t      push_pc;
    fetch_pkg::inst_t      push_inst;
    logic                  push_ex_valid;
    fetch_pkg::exc_cause_t push_ex_cause;
    logic                  queue_full;

    fetch_stage u_fetch_stage (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .redirect_valid_i    (redirect_valid_i),
        .redirect_pc_i       (redirect_pc_i),
        .busy_i              (busy),
        .resp_valid_i        (resp_valid),
        .resp_data_i         (resp_data),
        .resp_access_fault_i (resp_access_fault),
        .resp_page_fault_i   (resp_page_fault),
        .queue_full_i        (queue_full),
        .req_valid_o         (req_valid),
        .req_addr_o          (req_addr),
        .push_o              (push),
        .push_pc_o           (push_pc),
        .push_inst_o         (push_inst),
        .push_ex_valid_o     (push_ex_valid),
        .push_ex_cause_o     (push_ex_cause)
    );

    ibus_wb_master u_ibus_wb_master (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .req_valid_i         (req_valid),
        .req_addr_i          (req_addr),
        .ack_i               (ack_i),
        .err_i               (err_i),
        .dat_i               (dat_i),
        .busy_o              (busy),
        .resp_valid_o        (resp_valid),
        .resp_data_o         (resp_data),
        .resp_access_fault_o (resp_access_fault),
        .resp_page_fault_o   (resp_page_fault),
        .cyc_o               (cyc_o),
        .stb_o               (stb_o),
        .we_o                (we_o),
        .sel_o               (sel_o),
        .adr_o               (adr_o)
    );

    // a redirect also empties the queue
    fetch_queue u_fetch_queue (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .flush_i         (redirect_valid_i),
        .push_i          (push),
        .push_pc_i       (push_pc),
        .push_inst_i     (push_inst),
        .push_ex_valid_i (push_ex_valid),
        .push_ex_cause_i (push_ex_cause),
        .out_ready_i     (out_ready_i),
        .full_o          (queue_full),
        .out_valid_o     (out_valid_o),
        .out_pc_o        (out_pc_o),
        .out_inst_o      (out_inst_o),
        .out_ex_valid_o  (out_ex_valid_o),
        .out_ex_cause_o  (out_ex_cause_o)
    );

endmodule

/* source/ibus_wb_master.sv */
`timescale 1ns/1ns

module ibus_wb_master (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              req_valid_i,
    input  fetch_pkg::addr_t  req_addr_i,
    input  logic              ack_i,
    input  logic              err_i,
    input  fetch_pkg::inst_t  dat_i,
    output logic              busy_o,
    output logic              resp_valid_o,
    output fetch_pkg::inst_t  resp_data_o,
    output logic              resp_access_fault_o,
    output logic              resp_page_fault_o,
    output logic              cyc_o,
    output logic              stb_o,
    output logic              we_o,
    output logic [3:0]        sel_o,
    output fetch_pkg::addr_t  adr_o
);
    fetch_pkg::ibus_state_t state_q;

    logic             cyc_q;
    logic             stb_q;
    logic             access_fault_q;
    logic             page_fault_q;
    fetch_pkg::addr_t addr_q;
    fetch_pkg::inst_t data_q;
    logic             unmapped;
    logic             bus_done;

    // no translation, just a single mapped window
    assign unmapped = req_addr_i >= fetch_pkg::MAPPED_LIMIT;
    // slave ends the cycle either way
    assign bus_done = ack_i || err_i;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q        <= fetch_pkg::IBUS_IDLE;
            cyc_q          <= 1'b0;
            stb_q          <= 1'b0;
            access_fault_q <= 1'b0;
            page_fault_q   <= 1'b0;
        end else begin
            case (state_q)
                fetch_pkg::IBUS_IDLE: begin
                    if (req_valid_i) begin
                        access_fault_q <= 1'b0;
                        page_fault_q   <= unmapped;
                        if (unmapped) begin
                            // answer straight away, bus stays quiet
                            state_q <= fetch_pkg::IBUS_RESPOND;
                        end else begin
                            state_q <= fetch_pkg::IBUS_BUS;
                            cyc_q   <= 1'b1;
                            stb_q   <= 1'b1;
                        end
                    end
                end
                fetch_pkg::IBUS_BUS: begin
                    // classic cycle, strobes held until ack or err
                    if (bus_done) begin
                        state_q        <= fetch_pkg::IBUS_RESPOND;
                        cyc_q          <= 1'b0;
                        stb_q          <= 1'b0;
                        access_fault_q <= err_i;
                    end
                end
                default: begin
                    // single cycle response pulse
                    state_q <= fetch_pkg::IBUS_IDLE;
                end
            endcase
        end
    end

    // address and read data
    always_ff @(posedge clk_i) begin
        if (state_q == fetch_pkg::IBUS_IDLE && req_valid_i) begin
            addr_q <= req_addr_i;
            data_q <= '0;
        end else if (state_q == fetch_pkg::IBUS_BUS && ack_i) begin
            data_q <= dat_i;
        end
    end

    assign busy_o              = state_q != fetch_pkg::IBUS_IDLE;
    assign resp_valid_o        = state_q == fetch_pkg::IBUS_RESPOND;
    assign resp_data_o         = data_q;
    assign resp_access_fault_o = access_fault_q;
    assign resp_page_fault_o   = page_fault_q;

    // read only master, full words
    assign cyc_o = cyc_q;
    assign stb_o = stb_q;
    assign we_o  = 1'b0;
    assign sel_o = fetch_pkg::WB_SEL_ALL;
    assign adr_o = addr_q;

    // strobe only inside a cycle, and only while the fsm runs the bus
    a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rstn_i)
        stb_o |-> (cyc_o && state_q == fetch_pkg::IBUS_BUS));

    // address must not move under a waiting strobe
    a_adr_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (stb_o && !bus_done) |=> (stb_o && $stable(adr_o)));

endmodule

/* testbench/tb_fetch_top.sv */
`timescale 1ns/1ns

module tb_fetch_top;
    localparam int          CLK_PERIOD  = 20;
    localparam int          DRIVE_DELAY = 2;
    localparam int          TEST_CYCLES = 400;
    // worst entry: request, 3 waits, ack, response pulse, queue slot
    localparam int          MAX_LATENCY = 8;
    localparam int          WATCHDOG_NS = TEST_CYCLES * MAX_LATENCY * CLK_PERIOD + 2000;
    localparam int          RANDOM_SEED = 71;
    localparam logic [31:0] BOOT_PC     = 32'h0000_024C;
    localparam logic [31:0] UNMAPPED    = 32'h8000_0000;
    localparam logic [31:0] ERR_LO      = 32'h0000_1000;
    localparam logic [31:0] ERR_HI      = 32'h0000_10FF;
    localparam logic [31:0] DATA_KEY    = 32'h1357_0000;
    localparam logic [3:0]  CAUSE_MISALIGNED = 4'd0;
    localparam logic [3:0]  CAUSE_ACCESS     = 4'd1;
    localparam logic [3:0]  CAUSE_PAGE       = 4'd12;

    logic                  clk;
    logic                  rstn;
    logic                  redirect_valid;
    fetch_pkg::addr_t      redirect_pc;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [3:0]            sel;
    fetch_pkg::addr_t      adr;
    fetch_pkg::inst_t      dat;
    logic                  ack;
    logic                  err;
    logic                  out_ready;
    logic                  out_valid;
    fetch_pkg::addr_t      out_pc;
    fetch_pkg::inst_t      out_inst;
    logic                  out_ex_valid;
    fetch_pkg::exc_cause_t out_ex_cause;

    integer      seed;
    int          error_count;
    int          check_count;
    int          entry_count;
    int          plain_count;
    int          misaligned_count;
    int          access_count;
    int          page_count;
    int          kind;
    int          gap;
    logic [31:0] rnd;

    // model state: pc of the next entry to leave
    logic [31:0] exp_pc;
    // misaligned entry seen, nothing more until a redirect
    logic        exp_halted;
    logic        pc_misaligned;
    // bus history from the previous sample
    logic        last_cyc;
    logic        waiting_q;
    logic [31:0] last_adr;

    fetch_top dut (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .cyc_o            (cyc),
        .stb_o            (stb),
        .we_o             (we),
        .sel_o            (sel),
        .adr_o            (adr),
        .dat_i            (dat),
        .ack_i            (ack),
        .err_i            (err),
        .out_ready_i      (out_ready),
        .out_valid_o      (out_valid),
        .out_pc_o         (out_pc),
        .out_inst_o       (out_inst),
        .out_ex_valid_o   (out_ex_valid),
        .out_ex_cause_o   (out_ex_cause)
    );

    wb_imem_model #(
        .SEED   (RANDOM_SEED),
        .ERR_LO (ERR_LO),
        .ERR_HI (ERR_HI)
    ) imem (
        .clk_i  (clk),
        .rstn_i (rstn),
        .cyc_i  (cyc),
        .stb_i  (stb),
        .adr_i  (adr),
        .dat_o  (dat),
        .ack_o  (ack),
        .err_o  (err)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic flag_failure(input string what);
        error_count++;
        $display("failure at %0t ns: %s", $time, what);
    endtask

    task automatic expect_exception(input logic [3:0] cause);
        compare_value("out_ex_valid_o", {31'd0, out_ex_valid}, 32'd1);
        compare_value("out_ex_cause_o", {28'd0, out_ex_cause}, {28'd0, cause});
    endtask

    // classic read rules and the quiet bus while misaligned
    task automatic check_bus();
        if (stb && !cyc) begin
            flag_failure("stb_o is high without cyc_o");
        end
        if (cyc) begin
            compare_value("we_o", {31'd0, we}, 32'd0);
            compare_value("sel_o", {28'd0, sel}, 32'hF);
        end
        if (stb && adr >= UNMAPPED) begin
            flag_failure($sformatf("bus cycle started for unmapped address %h", adr));
        end
        if (waiting_q) begin
            if (!stb) begin
                flag_failure("stb_o dropped before ack or err");
            end
            compare_value("adr_o", adr, last_adr);
        end
        if (pc_misaligned && cyc && !last_cyc) begin
            flag_failure("cyc_o rose while the pc is misaligned");
        end
        last_cyc  = cyc;
        waiting_q = stb && !ack && !err;
        last_adr  = adr;
    endtask

    // one entry taken by decode against the model
    task automatic check_entry();
        entry_count++;
        if (exp_halted) begin
            flag_failure($sformatf("entry with pc %h left after a misaligned exception", out_pc));
        end else begin
            compare_value("out_pc_o", out_pc, exp_pc);
            if (|exp_pc[1:0]) begin
                // pc holds until the next redirect
                expect_exception(CAUSE_MISALIGNED);
                misaligned_count++;
                exp_halted = 1'b1;
            end else if (exp_pc >= UNMAPPED) begin
                expect_exception(CAUSE_PAGE);
                page_count++;
            end else if (exp_pc >= ERR_LO && exp_pc <= ERR_HI) begin
                expect_exception(CAUSE_ACCESS);
                access_count++;
            end else begin
                compare_value("out_ex_valid_o", {31'd0, out_ex_valid}, 32'd0);
                compare_value("out_inst_o", out_inst, exp_pc ^ DATA_KEY);
                plain_count++;
            end
            if (!exp_halted) begin
                exp_pc = exp_pc + 32'd4;
            end
        end
    endtask

    // kinds cycle: plain, misaligned, error window, unmapped
    function automatic logic [31:0] redirect_target(input int sel_kind, input logic [31:0] r);
        logic [31:0] pc;
        case (sel_kind)
            0: pc = 32'h0000_2000 | (r & 32'h0000_0FFC);
            1: begin
                pc      = 32'h0000_3000 | (r & 32'h0000_0FFC);
                pc[1:0] = (r[17:16] == 2'd0) ? 2'd2 : r[17:16];
            end
            2: pc = ERR_LO | (r & 32'h0000_00FC);
            default: pc = UNMAPPED | (r & 32'h7FFF_FFFC);
        endcase
        return pc;
    endfunction

    // sampled mid cycle, inputs and outputs both settled
    always @(negedge clk) begin
        if (rstn) begin
            check_bus();
            // handshake in a redirect cycle still belongs to the old path
            if (out_valid && out_ready) begin
                check_entry();
            end
            if (redirect_valid) begin
                exp_pc        = redirect_pc;
                exp_halted    = 1'b0;
                pc_misaligned = |redirect_pc[1:0];
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("entries %0d, checks %0d, errors %0d", entry_count, check_count, error_count);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        seed             = RANDOM_SEED;
        error_count      = 0;
        check_count      = 0;
        entry_count      = 0;
        plain_count      = 0;
        misaligned_count = 0;
        access_count     = 0;
        page_count       = 0;
        kind             = 0;
        gap              = 10;
        rnd              = '0;
        exp_pc           = BOOT_PC;
        exp_halted       = 1'b0;
        pc_misaligned    = 1'b0;
        last_cyc         = 1'b0;
        waiting_q        = 1'b0;
        last_adr         = '0;
        rstn             = 1'b0;
        redirect_valid   = 1'b0;
        redirect_pc      = '0;
        out_ready        = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rstn = 1'b1;
        // idle right out of reset
        @(negedge clk);
        compare_value("cyc_o", {31'd0, cyc}, 32'd0);
        compare_value("stb_o", {31'd0, stb}, 32'd0);
        compare_value("out_valid_o", {31'd0, out_valid}, 32'd0);
        for (int i = 0; i < TEST_CYCLES; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            // ready about three cycles in four
            out_ready = ($random(seed) & 3) != 0;
            rnd       = $random(seed);
            if (gap == 0) begin
                redirect_valid = 1'b1;
                redirect_pc    = redirect_target(kind, rnd);
                kind           = (kind + 1) % 4;
                gap            = 20 + {$random(seed)} % 21;
            end else begin
                redirect_valid = 1'b0;
                gap--;
            end
        end
        // back to the reset vector, then wait for its entry
        @(posedge clk);
        #DRIVE_DELAY;
        out_ready      = 1'b1;
        redirect_valid = 1'b1;
        redirect_pc    = BOOT_PC;
        @(posedge clk);
        #DRIVE_DELAY;
        redirect_valid = 1'b0;
        do begin
            @(negedge clk);
        end while (!(out_valid && out_ready));
        @(posedge clk);
        if (plain_count == 0) begin
            flag_failure("no plain instruction entry was seen");
        end
        if (misaligned_count == 0) begin
            flag_failure("no misaligned exception entry was seen");
        end
        if (access_count == 0) begin
            flag_failure("no access fault entry was seen");
        end
        if (page_count == 0) begin
            flag_failure("no page fault entry was seen");
        end
        $display("entries %0d, checks %0d, errors %0d", entry_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* testbench/wb_imem_model.sv */
`timescale 1ns/1ns

module wb_imem_model #(
    parameter int          SEED   = 71,
    parameter logic [31:0] ERR_LO = 32'h0000_1000,
    parameter logic [31:0] ERR_HI = 32'h0000_10FF
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic [31:0] adr_i,
    output logic [31:0] dat_o,
    output logic        ack_o,
    output logic        err_o
);
    // read data is a fixed function of the address
    localparam logic [31:0] DATA_KEY = 32'h1357_0000;

    integer     seed;
    // wait states left for the current transfer
    integer     waits;
    logic       active_q;
    logic [1:0] wait_q;

    initial begin
        seed = SEED;
    end

    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_o    <= 1'b0;
            err_o    <= 1'b0;
            dat_o    <= '0;
            active_q <= 1'b0;
            wait_q   <= 2'd0;
        end else begin
            // answers are single cycle pulses
            ack_o <= 1'b0;
            err_o <= 1'b0;
            // classic cycle, master holds strobe until it sees the answer
            if (cyc_i && stb_i && !ack_o && !err_o) begin
                // draw 0 to 3 wait states once per transfer
                if (active_q) begin
                    waits = wait_q;
                end else begin
                    waits = {$random(seed)} % 4;
                end
                if (waits == 0) begin
                    active_q <= 1'b0;
                    if (adr_i >= ERR_LO && adr_i <= ERR_HI) begin
                        // faulty window, no data
                        err_o <= 1'b1;
                    end else begin
                        ack_o <= 1'b1;
                        dat_o <= adr_i ^ DATA_KEY;
                    end
                end else begin
                    active_q <= 1'b1;
                    wait_q   <= waits[1:0] - 2'd1;
                end
            end
        end
    end

endmodule

/* verilog.f */
source/fetch_pkg.sv
source/fetch_stage.sv
source/ibus_wb_master.sv
source/fetch_queue.sv
source/fetch_top.sv
testbench/wb_imem_model.sv
testbench/tb_fetch_top.sv
